// ==== source/simd_alu_pkg.sv ====
package simd_alu_pkg;

  localparam int DATA_W = 32;

  typedef logic [DATA_W-1:0] data_t;
  typedef logic [31:0]       ctrl_t;   // Format in 31..24, opcode in 11..0
  typedef logic [7:0]        fmt_t;
  typedef logic [11:0]       opcode_t;
  typedef logic [3:0]        cmp_sel_t;  // {unsigned, condition}

  // Instruction formats
  localparam fmt_t FMT_VOP1  = 8'h01;
  localparam fmt_t FMT_VOP2  = 8'h02;
  localparam fmt_t FMT_VOPC  = 8'h04;
  localparam fmt_t FMT_VOP3A = 8'h08;

  localparam opcode_t OPC_MOV_B32     = 12'h001;  // VOP1
  localparam opcode_t OPC_CNDMASK_B32 = 12'h000;  // VOP2 from here on
  localparam opcode_t OPC_MIN_U32     = 12'h013;
  localparam opcode_t OPC_MAX_U32     = 12'h014;
  localparam opcode_t OPC_LSHRREV_B32 = 12'h016;
  localparam opcode_t OPC_LSHLREV_B32 = 12'h01A;
  localparam opcode_t OPC_AND_B32     = 12'h01B;
  localparam opcode_t OPC_OR_B32      = 12'h01C;
  localparam opcode_t OPC_ADD_I32     = 12'h025;
  localparam opcode_t OPC_SUB_I32     = 12'h026;
  localparam opcode_t OPC_SUBREV_I32  = 12'h027;
  localparam opcode_t OPC_ADDC_U32    = 12'h028;
  localparam opcode_t OPC_MUL_LO_U32  = 12'h169;  // VOP3A
  localparam opcode_t OPC_MUL_HI_U32  = 12'h16A;

  // The sixteen compares sit at 0x080..0x087 (signed) and 0x0C0..0x0C7 (unsigned).
  // Bit 6 picks unsigned, bits 2..0 the condition.
  localparam opcode_t OPC_CMP_BASE = 12'h080;
  localparam opcode_t OPC_CMP_MASK = 12'hFB8;

  localparam logic [2:0] CMP_F   = 3'd0;
  localparam logic [2:0] CMP_LT  = 3'd1;
  localparam logic [2:0] CMP_EQ  = 3'd2;
  localparam logic [2:0] CMP_LE  = 3'd3;
  localparam logic [2:0] CMP_GT  = 3'd4;
  localparam logic [2:0] CMP_LG  = 3'd5;
  localparam logic [2:0] CMP_GE  = 3'd6;
  localparam logic [2:0] CMP_TRU = 3'd7;

  typedef enum logic [1:0] {
    CLS_INT,
    CLS_MUL,
    CLS_SKIP,     // EXEC bit clear
    CLS_ILLEGAL
  } op_class_e;

  typedef enum logic [4:0] {
    INT_MOV, INT_ADD, INT_SUB, INT_SUBREV, INT_ADDC,
    INT_AND, INT_OR, INT_LSHL, INT_LSHR,
    INT_MAX, INT_MIN, INT_CNDMASK, INT_CMP
  } int_op_e;

  typedef enum logic {MUL_LO, MUL_HI} mul_op_e;

  typedef enum logic [1:0] {IDLE, RUN, DONE} mul_state_e;

endpackage

// ==== source/alu_decoder.sv ====
`timescale 1ns/1ps

module alu_decoder
  import simd_alu_pkg::*;
(
  input  logic      start,
  input  ctrl_t     ctrl,
  input  logic      exec_in,
  output logic      start_int,
  output logic      start_mul,
  output int_op_e   int_op,
  output cmp_sel_t  cmp_sel,
  output mul_op_e   mul_op,
  output op_class_e op_class
);

  fmt_t    fmt;
  opcode_t opc;

  assign fmt = ctrl[31:24];
  assign opc = ctrl[11:0];

  assign cmp_sel = {opc[6], opc[2:0]};  // Condition comes straight from the opcode

  always_comb
  begin
    op_class = CLS_ILLEGAL;  // Anything not matched below
    int_op   = INT_MOV;
    mul_op   = MUL_LO;
    if (!exec_in)
    begin
      op_class = CLS_SKIP;  // Lane masked off, opcode ignored
    end
    else
    begin
      case (fmt)
        FMT_VOP1:
        begin
          if (opc == OPC_MOV_B32)
            op_class = CLS_INT;
        end
        FMT_VOP2:
        begin
          op_class = CLS_INT;
          case (opc)
            OPC_CNDMASK_B32: int_op = INT_CNDMASK;
            OPC_MIN_U32:     int_op = INT_MIN;
            OPC_MAX_U32:     int_op = INT_MAX;
            OPC_LSHRREV_B32: int_op = INT_LSHR;
            OPC_LSHLREV_B32: int_op = INT_LSHL;
            OPC_AND_B32:     int_op = INT_AND;
            OPC_OR_B32:      int_op = INT_OR;
            OPC_ADD_I32:     int_op = INT_ADD;
            OPC_SUB_I32:     int_op = INT_SUB;
            OPC_SUBREV_I32:  int_op = INT_SUBREV;
            OPC_ADDC_U32:    int_op = INT_ADDC;
            default:         op_class = CLS_ILLEGAL;
          endcase
        end
        FMT_VOPC:
        begin
          if ((opc & OPC_CMP_MASK) == OPC_CMP_BASE)
          begin
            op_class = CLS_INT;
            int_op   = INT_CMP;
          end
        end
        FMT_VOP3A:
        begin
          if (opc == OPC_MUL_LO_U32 || opc == OPC_MUL_HI_U32)
            op_class = CLS_MUL;
          if (opc == OPC_MUL_HI_U32)
            mul_op = MUL_HI;
        end
        default: op_class = CLS_ILLEGAL;
      endcase
    end
  end

  // Skip and illegal still run through the integer unit for the done pulse
  assign start_int = start && (op_class != CLS_MUL);
  assign start_mul = start && (op_class == CLS_MUL);

endmodule

// ==== source/alu_int_unit.sv ====
`timescale 1ns/1ps

module alu_int_unit
  import simd_alu_pkg::*;
(
  input  logic      clk,
  input  logic      rst,
  input  logic      start_int,
  input  op_class_e op_class,
  input  int_op_e   int_op,
  input  cmp_sel_t  cmp_sel,
  input  data_t     src0,
  input  data_t     src1,
  input  logic      vcc_in,
  output logic      int_valid,
  output data_t     int_result,
  output logic      int_write,
  output logic      int_vcc,
  output logic      int_error
);

  data_t res_c;
  logic  write_c;
  logic  vcc_c;
  logic  err_c;
  logic  lt;
  logic  eq;
  logic  cmp_c;

  // Bit 3 of the select marks an unsigned compare
  assign lt = cmp_sel[3] ? (src0 < src1) : ($signed(src0) < $signed(src1));
  assign eq = (src0 == src1);

  always_comb
  begin
    case (cmp_sel[2:0])
      CMP_F:   cmp_c = 1'b0;
      CMP_LT:  cmp_c = lt;
      CMP_EQ:  cmp_c = eq;
      CMP_LE:  cmp_c = lt | eq;
      CMP_GT:  cmp_c = !(lt | eq);
      CMP_LG:  cmp_c = !eq;
      CMP_GE:  cmp_c = !lt;
      default: cmp_c = 1'b1;  // TRU
    endcase
  end

  always_comb
  begin
    res_c   = '0;
    write_c = 1'b0;
    vcc_c   = vcc_in;  // VCC passes through unless an op writes it
    err_c   = 1'b0;
    if (op_class == CLS_INT)
    begin
      write_c = 1'b1;
      case (int_op)
        INT_MOV:     res_c = src0;
        INT_ADD:     {vcc_c, res_c} = {1'b0, src0} + {1'b0, src1};  // Carry out to VCC
        INT_SUB:     {vcc_c, res_c} = {1'b0, src0} - {1'b0, src1};  // Borrow to VCC
        INT_SUBREV:  {vcc_c, res_c} = {1'b0, src1} - {1'b0, src0};
        INT_ADDC:    {vcc_c, res_c} = {1'b0, src0} + {1'b0, src1} + (DATA_W+1)'(vcc_in);
        INT_AND:     res_c = src0 & src1;
        INT_OR:      res_c = src0 | src1;
        INT_LSHL:    res_c = src1 << src0[4:0];
        INT_LSHR:    res_c = src1 >> src0[4:0];
        INT_MAX:     res_c = (src0 >= src1) ? src0 : src1;
        INT_MIN:     res_c = (src0 <= src1) ? src0 : src1;
        INT_CNDMASK: res_c = vcc_in ? src1 : src0;
        INT_CMP:
        begin
          write_c = 1'b0;  // Compares only touch VCC
          vcc_c   = cmp_c;
        end
        default:     write_c = 1'b0;
      endcase
    end
    else if (op_class == CLS_ILLEGAL)
    begin
      err_c = 1'b1;
    end
  end

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      int_valid <= 1'b0;
      int_write <= 1'b0;
      int_error <= 1'b0;
    end
    else
    begin
      int_valid <= start_int;
      if (start_int)
      begin
        int_write <= write_c;
        int_error <= err_c;
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (start_int)
    begin
      int_result <= res_c;
      int_vcc    <= vcc_c;
    end
  end

  // Decoder must route multiplies away from this unit
  a_no_mul_here: assert property (@(posedge clk) disable iff (rst)
    start_int |-> op_class != CLS_MUL);

endmodule

// ==== source/alu_mul_unit.sv ====
`timescale 1ns/1ps

module alu_mul_unit
  import simd_alu_pkg::*;
#(
  parameter int MUL_CYCLES = 2
)
(
  input  logic    clk,
  input  logic    rst,
  input  logic    start_mul,
  input  mul_op_e mul_op,
  input  data_t   src0,
  input  data_t   src1,
  output logic    mul_valid,
  output data_t   mul_result,
  output logic    busy
);

  localparam int CNT_W = $clog2(MUL_CYCLES + 1);

  mul_state_e            state;
  logic [CNT_W-1:0]      cnt;
  data_t                 op_a;
  data_t                 op_b;
  mul_op_e               op_q;
  logic [2*DATA_W-1:0]   product;

  assign product   = op_a * op_b;  // Array settles over the RUN cycles
  assign busy      = (state == RUN);
  assign mul_valid = (state == DONE);

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      state <= IDLE;
      cnt   <= '0;
    end
    else
    begin
      case (state)
        IDLE, DONE:
        begin
          if (start_mul)  // A new multiply may start in the done cycle
          begin
            state <= RUN;
            cnt   <= '0;
          end
          else
          begin
            state <= IDLE;
          end
        end
        RUN:
        begin
          if (cnt == CNT_W'(MUL_CYCLES - 1))
            state <= DONE;
          cnt <= cnt + 1'b1;
        end
        default: state <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (start_mul)
    begin
      op_a <= src0;
      op_b <= src1;
      op_q <= mul_op;
    end
    if (state == RUN && cnt == CNT_W'(MUL_CYCLES - 1))
      mul_result <= (op_q == MUL_HI) ? product[2*DATA_W-1:DATA_W] : product[DATA_W-1:0];
  end

  // Caller must wait for busy to drop
  a_no_start_busy: assert property (@(posedge clk) disable iff (rst)
    busy |-> !start_mul);

  // Each result pulse closes the multiply started MUL_CYCLES+1 cycles before
  a_valid_pulse: assert property (@(posedge clk) disable iff (rst)
    mul_valid |-> $past(start_mul, MUL_CYCLES + 1));

endmodule

// ==== source/alu_result_stage.sv ====
`timescale 1ns/1ps

module alu_result_stage
  import simd_alu_pkg::*;
(
  input  logic  clk,
  input  logic  rst,
  input  logic  int_valid,
  input  data_t int_result,
  input  logic  int_write,
  input  logic  int_vcc,
  input  logic  int_error,
  input  logic  mul_valid,
  input  data_t mul_result,
  input  logic  vcc_in,
  input  logic  busy,
  output data_t result,
  output logic  vgpr_write,
  output logic  vcc_out,
  output logic  error,
  output logic  done
);

  logic busy_q;
  logic vcc_q;     // vcc_in one cycle late, lines up with the busy rise
  logic vcc_hold;  // VCC of the multiply in flight

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      busy_q     <= 1'b0;
      done       <= 1'b0;
      vgpr_write <= 1'b0;
      error      <= 1'b0;
    end
    else
    begin
      busy_q     <= busy;
      done       <= int_valid | mul_valid;
      vgpr_write <= int_valid ? int_write : mul_valid;  // Multiplies always write
      error      <= int_valid & int_error;
    end
  end

  always_ff @(posedge clk)
  begin
    vcc_q <= vcc_in;
    if (busy && !busy_q)
      vcc_hold <= vcc_q;  // Start cycle value
    if (int_valid)
    begin
      result  <= int_result;
      vcc_out <= int_vcc;
    end
    else if (mul_valid)
    begin
      result  <= mul_result;
      vcc_out <= vcc_hold;
    end
  end

  a_one_source: assert property (@(posedge clk) disable iff (rst)
    !(int_valid && mul_valid));

endmodule

// ==== source/simd_alu.sv ====
`timescale 1ns/1ps

module simd_alu
  import simd_alu_pkg::*;
#(
  parameter int MUL_CYCLES = 2
)
(
  input  logic  clk,
  input  logic  rst,
  input  logic  start,
  input  ctrl_t ctrl,
  input  data_t src0,
  input  data_t src1,
  input  logic  vcc_in,
  input  logic  exec_in,
  output data_t result,
  output logic  vgpr_write,
  output logic  vcc_out,
  output logic  error,
  output logic  done,
  output logic  busy
);

  logic      start_int;
  logic      start_mul;
  int_op_e   int_op;
  cmp_sel_t  cmp_sel;
  mul_op_e   mul_op;
  op_class_e op_class;
  logic      int_valid;
  data_t     int_result;
  logic      int_write;
  logic      int_vcc;
  logic      int_error;
  logic      mul_valid;
  data_t     mul_result;

  alu_decoder alu_decoder_inst (
    .start     (start),
    .ctrl      (ctrl),
    .exec_in   (exec_in),
    .start_int (start_int),
    .start_mul (start_mul),
    .int_op    (int_op),
    .cmp_sel   (cmp_sel),
    .mul_op    (mul_op),
    .op_class  (op_class)
  );

  alu_int_unit alu_int_unit_inst (
    .clk        (clk),
    .rst        (rst),
    .start_int  (start_int),
    .op_class   (op_class),
    .int_op     (int_op),
    .cmp_sel    (cmp_sel),
    .src0       (src0),
    .src1       (src1),
    .vcc_in     (vcc_in),
    .int_valid  (int_valid),
    .int_result (int_result),
    .int_write  (int_write),
    .int_vcc    (int_vcc),
    .int_error  (int_error)
  );

  alu_mul_unit #(
    .MUL_CYCLES (MUL_CYCLES)
  ) alu_mul_unit_inst (
    .clk        (clk),
    .rst        (rst),
    .start_mul  (start_mul),
    .mul_op     (mul_op),
    .src0       (src0),
    .src1       (src1),
    .mul_valid  (mul_valid),
    .mul_result (mul_result),
    .busy       (busy)
  );

  alu_result_stage alu_result_stage_inst (
    .clk        (clk),
    .rst        (rst),
    .int_valid  (int_valid),
    .int_result (int_result),
    .int_write  (int_write),
    .int_vcc    (int_vcc),
    .int_error  (int_error),
    .mul_valid  (mul_valid),
    .mul_result (mul_result),
    .vcc_in     (vcc_in),
    .busy       (busy),
    .result     (result),
    .vgpr_write (vgpr_write),
    .vcc_out    (vcc_out),
    .error      (error),
    .done       (done)
  );

endmodule

// ==== tb/alu_ref_model.svh ====
`ifndef ALU_REF_MODEL_SVH
`define ALU_REF_MODEL_SVH

typedef struct packed {
  ctrl_t ctrl;
  data_t result;
  logic  write;
  logic  vcc;
  logic  error;
  int    latency;  // Clock edges from start to done
} expect_t;

function automatic expect_t alu_ref_model(input ctrl_t ctrl, input data_t src0,
                                          input data_t src1, input logic vcc_in,
                                          input logic exec_in);
  expect_t     e;
  opcode_t     opc;
  logic [63:0] wide;
  logic        lt;
  logic        gt;
  logic        eq;
  logic        legal;
  opc       = ctrl[11:0];
  e         = '0;
  e.ctrl    = ctrl;
  e.vcc     = vcc_in;  // Kept unless the op writes VCC
  e.latency = 2;
  legal     = 1'b1;
  wide      = '0;
  if (exec_in)
  begin
    e.write = 1'b1;
    case (ctrl[31:24])
      FMT_VOP1:
      begin
        legal    = (opc == OPC_MOV_B32);
        e.result = src0;
      end
      FMT_VOP2:
      begin
        case (opc)
          OPC_CNDMASK_B32: e.result = vcc_in ? src1 : src0;
          OPC_MIN_U32:     e.result = (src0 < src1) ? src0 : src1;
          OPC_MAX_U32:     e.result = (src0 > src1) ? src0 : src1;
          OPC_LSHRREV_B32: e.result = src1 >> src0[4:0];
          OPC_LSHLREV_B32: e.result = src1 << src0[4:0];
          OPC_AND_B32:     e.result = src0 & src1;
          OPC_OR_B32:      e.result = src0 | src1;
          OPC_SUB_I32:     e.result = src0 - src1;
          OPC_SUBREV_I32:  e.result = src1 - src0;
          OPC_ADD_I32, OPC_ADDC_U32:
          begin
            wide = {32'd0, src0} + {32'd0, src1};
            if (opc == OPC_ADDC_U32)
              wide = wide + {63'd0, vcc_in};
            e.result = wide[31:0];
            e.vcc    = wide[32];  // Carry out
          end
          default: legal = 1'b0;
        endcase
        if (opc == OPC_SUB_I32)
          e.vcc = (src0 < src1);  // Borrow
        if (opc == OPC_SUBREV_I32)
          e.vcc = (src1 < src0);
      end
      FMT_VOPC:
      begin
        legal   = (opc[11:7] == 5'b00001) && (opc[5:3] == 3'b000);
        e.write = 1'b0;
        lt      = opc[6] ? (src0 < src1) : ($signed(src0) < $signed(src1));
        gt      = opc[6] ? (src0 > src1) : ($signed(src0) > $signed(src1));
        eq      = (src0 == src1);
        case (opc[2:0])
          CMP_F:   e.vcc = 1'b0;
          CMP_LT:  e.vcc = lt;
          CMP_EQ:  e.vcc = eq;
          CMP_LE:  e.vcc = lt | eq;
          CMP_GT:  e.vcc = gt;
          CMP_LG:  e.vcc = !eq;
          CMP_GE:  e.vcc = gt | eq;
          default: e.vcc = 1'b1;
        endcase
      end
      FMT_VOP3A:
      begin
        legal     = (opc == OPC_MUL_LO_U32) || (opc == OPC_MUL_HI_U32);
        wide      = {32'd0, src0} * {32'd0, src1};
        e.result  = (opc == OPC_MUL_HI_U32) ? wide[63:32] : wide[31:0];
        e.latency = MUL_CYCLES + 2;
      end
      default: legal = 1'b0;
    endcase
    if (!legal)
    begin
      e.result  = '0;
      e.write   = 1'b0;
      e.vcc     = vcc_in;
      e.error   = 1'b1;
      e.latency = 2;
    end
  end
  return e;
endfunction

`endif

// ==== tb/tb_simd_alu.sv ====
`timescale 1ns/1ps

module tb_simd_alu
  import simd_alu_pkg::*;
();

  localparam int MUL_CYCLES = 2;
  localparam int N_RAND     = 12;  // Random rounds per integer op
  localparam int N_RAND_CMP = 4;
  localparam int N_RAND_MUL = 6;
  localparam int N_SKIP     = 12;
  localparam int N_ILLEGAL  = 7;
  localparam int N_BURST    = 8;
  localparam int N_INSTR    = 12 * N_RAND + 16 * (N_RAND_CMP + 6) + 2 * (N_RAND_MUL + 1)
                              + N_SKIP + N_ILLEGAL + 3 * N_BURST;
  localparam longint WATCHDOG_NS = (N_INSTR * 10 + 100) * 20;

  logic  clk;
  logic  rst;
  logic  start;
  ctrl_t ctrl;
  data_t src0;
  data_t src1;
  logic  vcc_in;
  logic  exec_in;
  data_t result;
  logic  vgpr_write;
  logic  vcc_out;
  logic  error;
  logic  done;
  logic  busy;

  int n_pass    = 0;
  int n_fail    = 0;
  int n_issued  = 0;
  int done_seen = 0;
  int busy_seen = 0;

  `include "alu_ref_model.svh"

  expect_t pending[$];  // Issued, not yet completed

  simd_alu #(
    .MUL_CYCLES (MUL_CYCLES)
  ) simd_alu_inst (
    .clk        (clk),
    .rst        (rst),
    .start      (start),
    .ctrl       (ctrl),
    .src0       (src0),
    .src1       (src1),
    .vcc_in     (vcc_in),
    .exec_in    (exec_in),
    .result     (result),
    .vgpr_write (vgpr_write),
    .vcc_out    (vcc_out),
    .error      (error),
    .done       (done),
    .busy       (busy)
  );

  initial
  begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  function automatic ctrl_t make_ctrl(input fmt_t fmt, input opcode_t opc);
    return {fmt, 12'h000, opc};
  endfunction

  // Index 0 is the VOP1 move, the rest are VOP2
  function automatic ctrl_t int_ctrl(input int k);
    case (k)
      0:       return make_ctrl(FMT_VOP1, OPC_MOV_B32);
      1:       return make_ctrl(FMT_VOP2, OPC_CNDMASK_B32);
      2:       return make_ctrl(FMT_VOP2, OPC_MIN_U32);
      3:       return make_ctrl(FMT_VOP2, OPC_MAX_U32);
      4:       return make_ctrl(FMT_VOP2, OPC_LSHRREV_B32);
      5:       return make_ctrl(FMT_VOP2, OPC_LSHLREV_B32);
      6:       return make_ctrl(FMT_VOP2, OPC_AND_B32);
      7:       return make_ctrl(FMT_VOP2, OPC_OR_B32);
      8:       return make_ctrl(FMT_VOP2, OPC_ADD_I32);
      9:       return make_ctrl(FMT_VOP2, OPC_SUB_I32);
      10:      return make_ctrl(FMT_VOP2, OPC_SUBREV_I32);
      default: return make_ctrl(FMT_VOP2, OPC_ADDC_U32);
    endcase
  endfunction

  function automatic ctrl_t cmp_ctrl(input int u, input int c);
    return make_ctrl(FMT_VOPC, OPC_CMP_BASE | opcode_t'(u * 64 + c));  // Bit 6 is unsigned
  endfunction

  function automatic ctrl_t illegal_ctrl(input int k);
    case (k)
      0:       return make_ctrl(8'h10, OPC_MOV_B32);
      1:       return make_ctrl(FMT_VOP1, 12'h002);
      2:       return make_ctrl(FMT_VOP2, 12'h050);
      3:       return make_ctrl(FMT_VOPC, 12'h090);
      4:       return make_ctrl(FMT_VOP3A, 12'h100);
      5:       return make_ctrl(FMT_VOP3A, OPC_ADD_I32);
      default: return make_ctrl(8'h00, 12'h000);
    endcase
  endfunction

  task automatic check_data(input string sig, input data_t got, input data_t exp,
                            input ctrl_t c);
    if (got !== exp)
    begin
      n_fail++;
      $display("FAIL %s: got 0x%h, expected 0x%h, ctrl 0x%h", sig, got, exp, c);
    end
    else
      n_pass++;
  endtask

  task automatic check_bit(input string sig, input logic got, input logic exp,
                           input ctrl_t c);
    if (got !== exp)
    begin
      n_fail++;
      $display("FAIL %s: got 0x%h, expected 0x%h, ctrl 0x%h", sig, got, exp, c);
    end
    else
      n_pass++;
  endtask

  // One clock edge, sampling the handshake outputs
  task automatic step();
    @(posedge clk);
    if (done)
      done_seen++;
    if (busy)
      busy_seen++;
  endtask

  task automatic issue(input ctrl_t c, input data_t a, input data_t b, input logic v,
                       input logic x);
    step();
    start   <= 1'b1;
    ctrl    <= c;
    src0    <= a;
    src1    <= b;
    vcc_in  <= v;
    exec_in <= x;
    pending.push_back(alu_ref_model(c, a, b, v, x));
    n_issued++;
  endtask

  task automatic wait_all();
    step();
    start <= 1'b0;
    while (done_seen < n_issued)
      step();
  endtask

  task automatic report_test(input string name, input int i0, input int f0);
    step();  // Checker has handled the last done by now
    $display("Test %s: %0d instructions, %0d failures", name, n_issued - i0, n_fail - f0);
  endtask

  initial
  begin : compare_outputs
    int      cyc;
    int      lat;
    int      starts[$];
    expect_t e;
    cyc = 0;
    forever
    begin
      @(posedge clk);
      cyc++;
      if (start && !rst)
        starts.push_back(cyc);
      if (done)
      begin
        if (pending.size() == 0 || starts.size() == 0)
        begin
          n_fail++;
          $display("Done pulse arrived with no instruction outstanding");
        end
        else
        begin
          e   = pending.pop_front();
          lat = cyc - starts.pop_front();
          check_bit("vgpr_write", vgpr_write, e.write, e.ctrl);
          if (e.write)
            check_data("result", result, e.result, e.ctrl);
          check_bit("vcc_out", vcc_out, e.vcc, e.ctrl);
          check_bit("error", error, e.error, e.ctrl);
          if (lat != e.latency)
          begin
            n_fail++;
            $display("Instruction ctrl 0x%h finished %0d cycles after start, expected %0d",
                     e.ctrl, lat, e.latency);
          end
          else
            n_pass++;
        end
      end
    end
  end

  initial
  begin : watchdog
    #(WATCHDOG_NS);
    $display("Timeout after %0d ns, the DUT stopped completing instructions", WATCHDOG_NS);
    $display("TESTS FAILED");
    $finish;
  end

  initial
  begin : drive_tests
    data_t edge_a [5];
    data_t edge_b [5];
    data_t a;
    ctrl_t mc;
    int    i0;
    int    f0;
    int    k;
    edge_a = '{32'h0000_0000, 32'h8000_0000, 32'h7FFF_FFFF, 32'hFFFF_FFFF, 32'h0000_0000};
    edge_b = '{32'h0000_0000, 32'h7FFF_FFFF, 32'h8000_0000, 32'h0000_0000, 32'hFFFF_FFFF};
    void'($urandom(20853));
    rst     = 1'b1;
    start   = 1'b0;
    ctrl    = '0;
    src0    = '0;
    src1    = '0;
    vcc_in  = 1'b0;
    exec_in = 1'b1;
    repeat (3) @(posedge clk);
    rst <= 1'b0;

    i0 = n_issued;
    f0 = n_fail;
    for (int op = 0; op < 12; op++)
    begin
      for (int i = 0; i < N_RAND; i++)
      begin
        issue(int_ctrl(op), $urandom(), $urandom(), (i % 2) == 1, 1'b1);  // VCC both ways
        wait_all();
      end
    end
    report_test("integer ops", i0, f0);

    i0 = n_issued;
    f0 = n_fail;
    for (int u = 0; u < 2; u++)
    begin
      for (int c = 0; c < 8; c++)
      begin
        for (int j = 0; j < N_RAND_CMP; j++)
        begin
          issue(cmp_ctrl(u, c), $urandom(), $urandom(), (j % 2) == 1, 1'b1);
          wait_all();
        end
        a = $urandom();
        issue(cmp_ctrl(u, c), a, a, 1'b0, 1'b1);
        wait_all();
        for (int j = 0; j < 5; j++)
        begin
          issue(cmp_ctrl(u, c), edge_a[j], edge_b[j], 1'b1, 1'b1);  // Sign boundaries
          wait_all();
        end
      end
    end
    report_test("compares", i0, f0);

    i0 = n_issued;
    f0 = n_fail;
    for (int m = 0; m < 2; m++)
    begin
      mc = make_ctrl(FMT_VOP3A, (m == 0) ? OPC_MUL_LO_U32 : OPC_MUL_HI_U32);
      for (int j = 0; j <= N_RAND_MUL; j++)
      begin
        busy_seen = 0;
        if (j == N_RAND_MUL)
          issue(mc, '1, '1, 1'b1, 1'b1);
        else
          issue(mc, $urandom(), $urandom(), (j % 2) == 1, 1'b1);
        wait_all();
        if (busy_seen != MUL_CYCLES)
        begin
          n_fail++;
          $display("Busy was high for %0d cycles of a multiply, expected %0d",
                   busy_seen, MUL_CYCLES);
        end
        else
          n_pass++;
      end
    end
    report_test("multiplies", i0, f0);

    i0 = n_issued;
    f0 = n_fail;
    for (int j = 0; j < N_SKIP; j++)
    begin
      if (j == 0)
        mc = make_ctrl(FMT_VOP3A, OPC_MUL_HI_U32);
      else if (j == 1)
        mc = int_ctrl(8);
      else
        mc = ctrl_t'($urandom());
      issue(mc, $urandom(), $urandom(), (j % 2) == 1, 1'b0);
      wait_all();
    end
    report_test("exec masked", i0, f0);

    i0 = n_issued;
    f0 = n_fail;
    for (int j = 0; j < N_ILLEGAL; j++)
    begin
      issue(illegal_ctrl(j), $urandom(), $urandom(), (j % 2) == 1, 1'b1);
      wait_all();
    end
    report_test("illegal", i0, f0);

    i0 = n_issued;
    f0 = n_fail;
    for (int b = 0; b < 3; b++)
    begin
      for (int j = 0; j < N_BURST; j++)
      begin
        k = $urandom_range(12, 0);
        if (k < 12)
          mc = int_ctrl(k);
        else
          mc = cmp_ctrl(j % 2, j % 8);
        issue(mc, $urandom(), $urandom(), (j % 2) == 1, 1'b1);  // No gap between starts
      end
      wait_all();
    end
    report_test("back to back", i0, f0);

    if (pending.size() != 0)
    begin
      n_fail++;
      $display("%0d instructions never completed", pending.size());
    end
    $display("Checks passed: %0d, failed: %0d", n_pass, n_fail);
    if (n_fail == 0)
      $display("TESTS PASSED");
    else
      $display("TESTS FAILED");
    $finish;
  end

endmodule

// ==== filelist.f ====
+incdir+tb
source/simd_alu_pkg.sv
source/alu_decoder.sv
source/alu_int_unit.sv
source/alu_mul_unit.sv
source/alu_result_stage.sv
source/simd_alu.sv
tb/tb_simd_alu.sv

// ==== run_sim.sh ====
#!/bin/sh
# Compile and run the testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_simd_alu -f filelist.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

output=$(./obj_dir/Vtb_simd_alu)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -qx "TESTS PASSED"; then
  exit 0
fi
echo "Pass message not found in simulation output"
exit 1
